// ==== rtl/ordered_drain.sv ====
`timescale 1ns/100ps

module ordered_drain
    import rdq_pkg::*;
#(
    parameter int DATA_BITS = DEFAULT_DATA_BITS,
    parameter int ADDR_BITS = DEFAULT_ADDR_BITS
)
(
    input  logic                 clk,
    input  logic                 resetb,
    input  logic                 not_empty,
    input  logic [DATA_BITS-1:0] first_data,
    input  logic [ADDR_BITS:0]   first_meta,
    input  logic                 out_stall,
    output logic                 deq_en,
    output logic                 out_valid,
    output logic [ADDR_BITS-1:0] out_addr,
    output logic [DATA_BITS-1:0] out_data,
    output logic [DATA_BITS-1:0] out_sum,
    output logic                 done
);

    // High when the next word opens a new burst and the sum starts over
    logic sum_restart;
    logic first_last;

    // The top meta bit is the last flag, the rest is the address
    assign first_last = first_meta[ADDR_BITS];

    // Take the oldest word whenever one is ready and the consumer is not holding off
    assign deq_en = not_empty && !out_stall;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            out_valid   <= 1'b0;
            done        <= 1'b0;
            sum_restart <= 1'b1;
        end
        else
        begin
            out_valid <= deq_en;
            done      <= deq_en && first_last;
            if (deq_en)
            begin
                sum_restart <= first_last;
            end
        end
    end

    // Sum wraps at the data width
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            out_addr <= first_meta[ADDR_BITS-1:0];
            out_data <= first_data;
            out_sum  <= (sum_restart ? '0 : out_sum) + first_data;
        end
    end

endmodule

// ==== rtl/out_stage.sv ====
`timescale 1ns/100ps

module out_stage
    import rdq_pkg::*;
#(
    parameter int DATA_BITS = DEFAULT_DATA_BITS,
    parameter int ADDR_BITS = DEFAULT_ADDR_BITS
)
(
    input  logic                 clk,
    input  logic                 resetb,
    input  logic                 wr_en,
    input  logic [DATA_BITS-1:0] wr_data_word,
    input  logic [ADDR_BITS:0]   wr_meta,
    input  logic                 rd_en,
    output logic                 full,
    output logic                 empty,
    output logic [DATA_BITS-1:0] rd_data_word,
    output logic [ADDR_BITS:0]   rd_meta
);

    // Set while the register holds an entry that the consumer has not taken yet
    logic occupied;

    assign full  = occupied;
    assign empty = !occupied;

    // A write is only issued while empty and a read only while full,
    // so the two never meet in one cycle
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            occupied <= 1'b0;
        end
        else
        begin
            occupied <= wr_en || (occupied && !rd_en);
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            rd_data_word <= wr_data_word;
            rd_meta      <= wr_meta;
        end
    end

endmodule

// ==== rtl/rdq_pkg.sv ====
package rdq_pkg;

    // The issuer is either waiting for a command or walking through a burst
    typedef enum logic [0:0]
    {
        IDLE    = 1'b0,
        ISSUING = 1'b1
    } t_issue_state;

    // Scoreboard depth in slots; one slot always stays empty to tell full from empty
    localparam int DEFAULT_N_ENTRIES = 16;

    // Width of a returned data word
    // The scoreboard memory stores half a word per address, so this must be even
    localparam int DEFAULT_DATA_BITS = 32;

    // Width of a request address
    localparam int DEFAULT_ADDR_BITS = 16;

    // Width of the burst length in a command
    localparam int DEFAULT_COUNT_BITS = 8;

endpackage

// ==== rtl/read_engine_top.sv ====
`timescale 1ns/100ps

module read_engine_top
    import rdq_pkg::*;
#(
    parameter int N_ENTRIES  = DEFAULT_N_ENTRIES,
    parameter int DATA_BITS  = DEFAULT_DATA_BITS,
    parameter int ADDR_BITS  = DEFAULT_ADDR_BITS,
    parameter int COUNT_BITS = DEFAULT_COUNT_BITS
)
(
    input  logic                         clk,
    input  logic                         resetb,
    input  logic                         start,
    input  logic [ADDR_BITS-1:0]         base_addr,
    input  logic [COUNT_BITS-1:0]        count,
    input  logic                         rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0] rsp_tag,
    input  logic [DATA_BITS-1:0]         rsp_data,
    input  logic                         out_stall,
    output logic                         busy,
    output logic                         req_valid,
    output logic [$clog2(N_ENTRIES)-1:0] req_tag,
    output logic [ADDR_BITS-1:0]         req_addr,
    output logic                         out_valid,
    output logic [ADDR_BITS-1:0]         out_addr,
    output logic [DATA_BITS-1:0]         out_data,
    output logic [DATA_BITS-1:0]         out_sum,
    output logic                         done
);

    localparam int TAG_BITS = $clog2(N_ENTRIES);

    // Allocation side between issuer and scoreboard
    logic                enq_en;
    logic [ADDR_BITS:0]  enq_meta;
    logic                not_full;
    logic [TAG_BITS-1:0] enq_idx;

    // Ordered side between scoreboard and drain
    logic                 deq_en;
    logic                 not_empty;
    logic [DATA_BITS-1:0] first_data;
    logic [ADDR_BITS:0]   first_meta;

    read_issuer #(
        .N_ENTRIES  (N_ENTRIES),
        .ADDR_BITS  (ADDR_BITS),
        .COUNT_BITS (COUNT_BITS)
    ) u_issuer (
        .clk       (clk),
        .resetb    (resetb),
        .start     (start),
        .base_addr (base_addr),
        .count     (count),
        .not_full  (not_full),
        .enq_idx   (enq_idx),
        .busy      (busy),
        .enq_en    (enq_en),
        .enq_meta  (enq_meta),
        .req_valid (req_valid),
        .req_tag   (req_tag),
        .req_addr  (req_addr)
    );

    // Memory responses land directly on the scoreboard's data write port
    reorder_scoreboard #(
        .N_ENTRIES (N_ENTRIES),
        .DATA_BITS (DATA_BITS),
        .ADDR_BITS (ADDR_BITS)
    ) u_scoreboard (
        .clk          (clk),
        .resetb       (resetb),
        .enq_en       (enq_en),
        .enq_meta     (enq_meta),
        .enq_data_en  (rsp_valid),
        .enq_data_idx (rsp_tag),
        .enq_data     (rsp_data),
        .deq_en       (deq_en),
        .not_full     (not_full),
        .enq_idx      (enq_idx),
        .not_empty    (not_empty),
        .first_data   (first_data),
        .first_meta   (first_meta)
    );

    ordered_drain #(
        .DATA_BITS (DATA_BITS),
        .ADDR_BITS (ADDR_BITS)
    ) u_drain (
        .clk        (clk),
        .resetb     (resetb),
        .not_empty  (not_empty),
        .first_data (first_data),
        .first_meta (first_meta),
        .out_stall  (out_stall),
        .deq_en     (deq_en),
        .out_valid  (out_valid),
        .out_addr   (out_addr),
        .out_data   (out_data),
        .out_sum    (out_sum),
        .done       (done)
    );

endmodule

// ==== rtl/read_issuer.sv ====
`timescale 1ns/100ps

module read_issuer
    import rdq_pkg::*;
#(
    parameter int N_ENTRIES  = DEFAULT_N_ENTRIES,
    parameter int ADDR_BITS  = DEFAULT_ADDR_BITS,
    parameter int COUNT_BITS = DEFAULT_COUNT_BITS
)
(
    input  logic                         clk,
    input  logic                         resetb,
    input  logic                         start,
    input  logic [ADDR_BITS-1:0]         base_addr,
    input  logic [COUNT_BITS-1:0]        count,
    input  logic                         not_full,
    input  logic [$clog2(N_ENTRIES)-1:0] enq_idx,
    output logic                         busy,
    output logic                         enq_en,
    output logic [ADDR_BITS:0]           enq_meta,
    output logic                         req_valid,
    output logic [$clog2(N_ENTRIES)-1:0] req_tag,
    output logic [ADDR_BITS-1:0]         req_addr
);

    t_issue_state          state;
    logic [ADDR_BITS-1:0]  next_addr;
    logic [COUNT_BITS-1:0] remain;
    logic                  issue;
    logic                  last;

    // One request per cycle while the scoreboard has a free slot
    assign issue = (state == ISSUING) && not_full;
    assign last  = (remain == COUNT_BITS'(1));

    assign busy      = (state == ISSUING);
    assign enq_en    = issue;
    assign req_valid = issue;
    // The slot index doubles as the memory tag
    assign req_tag   = enq_idx;
    assign req_addr  = next_addr;
    assign enq_meta  = {last, next_addr};

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state  <= IDLE;
            remain <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    // Zero-length commands are dropped here
                    if (start && (count != '0))
                    begin
                        state  <= ISSUING;
                        remain <= count;
                    end
                end
                ISSUING:
                begin
                    if (issue)
                    begin
                        remain <= remain - COUNT_BITS'(1);
                        if (last)
                        begin
                            state <= IDLE;
                        end
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Address walks up by one per request
    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && start)
        begin
            next_addr <= base_addr;
        end
        else if (issue)
        begin
            next_addr <= next_addr + ADDR_BITS'(1);
        end
    end

endmodule

// ==== rtl/reorder_scoreboard.sv ====
`timescale 1ns/100ps

module reorder_scoreboard
    import rdq_pkg::*;
#(
    parameter int N_ENTRIES = DEFAULT_N_ENTRIES,
    parameter int DATA_BITS = DEFAULT_DATA_BITS,
    parameter int ADDR_BITS = DEFAULT_ADDR_BITS
)
(
    input  logic                         clk,
    input  logic                         resetb,
    input  logic                         enq_en,
    input  logic [ADDR_BITS:0]           enq_meta,
    input  logic                         enq_data_en,
    input  logic [$clog2(N_ENTRIES)-1:0] enq_data_idx,
    input  logic [DATA_BITS-1:0]         enq_data,
    input  logic                         deq_en,
    output logic                         not_full,
    output logic [$clog2(N_ENTRIES)-1:0] enq_idx,
    output logic                         not_empty,
    output logic [DATA_BITS-1:0]         first_data,
    output logic [ADDR_BITS:0]           first_meta
);

    localparam int TAG_BITS  = $clog2(N_ENTRIES);
    localparam int HALF_BITS = DATA_BITS / 2;

    // Allocation and release pointers
    // Equal pointers mean empty, newest one behind oldest means full
    logic [TAG_BITS-1:0] newest;
    logic [TAG_BITS-1:0] oldest;
    logic [TAG_BITS-1:0] oldest_next;

    // One bit per slot, set once the memory has answered for that slot
    logic [N_ENTRIES-1:0] data_valid;
    logic [N_ENTRIES-1:0] data_valid_next;

    // Registered request to move the oldest entry into the output stage
    logic release_req;
    logic release_en;

    logic stage_full;
    logic stage_empty;

    // Half-width data store, two addresses per slot
    logic [HALF_BITS-1:0] data_mem [0:2*N_ENTRIES-1];
    logic [HALF_BITS-1:0] rd_lo;
    logic [HALF_BITS-1:0] rd_hi;
    logic [TAG_BITS-1:0]  ram_addr;

    // Meta-data store, written at allocation time
    logic [ADDR_BITS:0] meta_mem [0:N_ENTRIES-1];
    logic [ADDR_BITS:0] meta_oldest;

    assign not_full  = ((newest + TAG_BITS'(1)) != oldest);
    assign enq_idx   = newest;
    assign not_empty = !stage_empty;

    // The release only completes when the output stage has room
    assign release_en  = release_req && !stage_full;
    assign oldest_next = oldest + TAG_BITS'(release_en);

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            newest <= '0;
            oldest <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                newest <= newest + TAG_BITS'(1);
            end
            oldest <= oldest_next;
        end
    end

    // A response write owns both memory ports, otherwise they read the next oldest slot
    assign ram_addr = enq_data_en ? enq_data_idx : oldest_next;

    // Port A handles the low half at even addresses and port B the high half at odd ones
    // The written value is bypassed to the read register as in a dual-write-port RAM
    always_ff @(posedge clk)
    begin
        if (enq_data_en)
        begin
            data_mem[{ram_addr, 1'b0}] <= enq_data[HALF_BITS-1:0];
            data_mem[{ram_addr, 1'b1}] <= enq_data[DATA_BITS-1:HALF_BITS];
            rd_lo <= enq_data[HALF_BITS-1:0];
            rd_hi <= enq_data[DATA_BITS-1:HALF_BITS];
        end
        else
        begin
            rd_lo <= data_mem[{ram_addr, 1'b0}];
            rd_hi <= data_mem[{ram_addr, 1'b1}];
        end
    end

    // Meta-data has its own memory and is read every cycle alongside the data
    always_ff @(posedge clk)
    begin
        meta_oldest <= meta_mem[oldest_next];
        if (enq_en)
        begin
            meta_mem[newest] <= enq_meta;
        end
    end

    // Clear a slot's valid bit as it leaves, set it as its response lands
    always_comb
    begin
        data_valid_next = data_valid;
        if (release_en)
        begin
            data_valid_next[oldest] = 1'b0;
        end
        if (enq_data_en)
        begin
            data_valid_next[enq_data_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            data_valid  <= '0;
            release_req <= 1'b0;
        end
        else
        begin
            data_valid <= data_valid_next;
            // Request a release only when the read ports are free this cycle,
            // since a response write takes both of them
            release_req <= data_valid[oldest_next] && !enq_data_en;
        end
    end

    out_stage #(
        .DATA_BITS (DATA_BITS),
        .ADDR_BITS (ADDR_BITS)
    ) u_out_stage (
        .clk          (clk),
        .resetb       (resetb),
        .wr_en        (release_en),
        .wr_data_word ({rd_hi, rd_lo}),
        .wr_meta      (meta_oldest),
        .rd_en        (deq_en),
        .full         (stage_full),
        .empty        (stage_empty),
        .rd_data_word (first_data),
        .rd_meta      (first_meta)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status follows the simulation
cd "$(dirname "$0")" && \
verilator --binary --timing --top-module read_engine_tb -f sources.f -o read_engine_sim && \
./obj_dir/read_engine_sim || exit 1

// ==== sources.f ====
rtl/rdq_pkg.sv
rtl/out_stage.sv
rtl/reorder_scoreboard.sv
rtl/read_issuer.sv
rtl/ordered_drain.sv
rtl/read_engine_top.sv
verification/read_engine_tb.sv

// ==== verification/read_engine_tb.sv ====
`timescale 1ns/100ps

module read_engine_tb
    import rdq_pkg::*;
();

    localparam int N_ENTRIES  = DEFAULT_N_ENTRIES;
    localparam int DATA_BITS  = DEFAULT_DATA_BITS;
    localparam int ADDR_BITS  = DEFAULT_ADDR_BITS;
    localparam int COUNT_BITS = DEFAULT_COUNT_BITS;
    localparam int TAG_BITS   = $clog2(N_ENTRIES);
    localparam int SEED       = 78169;

    // Burst table, one row per burst: base address, word count,
    // memory reorder depth and output stall percentage
    // A depth of N_ENTRIES holds every response back while the issuer keeps sending
    localparam int NUM_ROWS = 8;
    localparam int ROW_BASE  [NUM_ROWS] = '{'h0100, 'h0200, 'h1000, 'h2000,
                                            'h3000, 'h4000, 'hFFF0, 'h5000};
    localparam int ROW_COUNT [NUM_ROWS] = '{1, 8, 12, 0, 40, 30, 20, 255};
    localparam int ROW_DEPTH [NUM_ROWS] = '{1, 1, 4, 1, N_ENTRIES, 6, 8, 15};
    localparam int ROW_STALL [NUM_ROWS] = '{0, 0, 0, 0, 0, 50, 25, 30};

    logic                 clk = 1'b0;
    logic                 resetb;
    logic                 start;
    logic [ADDR_BITS-1:0] base_addr;
    logic [COUNT_BITS-1:0] count;
    logic                 rsp_valid = 1'b0;
    logic [TAG_BITS-1:0]  rsp_tag = '0;
    logic [DATA_BITS-1:0] rsp_data = '0;
    logic                 out_stall = 1'b0;
    logic                 busy;
    logic                 req_valid;
    logic [TAG_BITS-1:0]  req_tag;
    logic [ADDR_BITS-1:0] req_addr;
    logic                 out_valid;
    logic [ADDR_BITS-1:0] out_addr;
    logic [DATA_BITS-1:0] out_data;
    logic [DATA_BITS-1:0] out_sum;
    logic                 done;

    // Settings of the burst in progress, as seen by the memory model and stall driver
    int mem_depth = 1;
    int stall_pct = 0;
    logic started = 1'b0;

    // Slots are handed out in order, so tags count up from zero and wrap
    logic [TAG_BITS-1:0]  exp_tag = '0;

    // Requests the issuer should still send, in order
    logic [ADDR_BITS-1:0] exp_req_addr [$];
    // Requests the memory has taken but not yet answered
    logic [TAG_BITS-1:0]  pend_tag [$];
    logic [ADDR_BITS-1:0] pend_addr [$];
    // Words the output should still deliver, in order
    logic [ADDR_BITS-1:0] exp_addr [$];
    logic [DATA_BITS-1:0] exp_data [$];
    logic [DATA_BITS-1:0] exp_sum [$];
    logic                 exp_last [$];

    read_engine_top uut (
        .clk       (clk),
        .resetb    (resetb),
        .start     (start),
        .base_addr (base_addr),
        .count     (count),
        .rsp_valid (rsp_valid),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data),
        .out_stall (out_stall),
        .busy      (busy),
        .req_valid (req_valid),
        .req_tag   (req_tag),
        .req_addr  (req_addr),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_data  (out_data),
        .out_sum   (out_sum),
        .done      (done)
    );

    initial
    begin
        forever #10 clk = ~clk;
    end

    // Memory contents as a function of the address
    function automatic logic [DATA_BITS-1:0] word_for_addr(input logic [ADDR_BITS-1:0] a);
        logic [63:0] p;
        p = 64'(a) * 64'h9E37;
        return DATA_BITS'(p ^ 64'h5A5A_0000);
    endfunction

    function automatic int total_words();
        int n;
        n = 0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            n = n + ROW_COUNT[r];
        end
        return n;
    endfunction

    task automatic check_value(input logic [63:0] expected, input logic [63:0] actual,
                               input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0t ns: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped on error");
    endtask

    // Out-of-order memory: holds requests back while the issuer keeps sending,
    // then answers a random one among the oldest mem_depth entries
    always @(posedge clk)
    begin : memory_model
        int window;
        int pick;
        rsp_valid <= 1'b0;
        if (resetb && req_valid)
        begin
            if (exp_req_addr.size() == 0)
                report_failure("request issued while no request was expected");
            check_value(64'(exp_req_addr[0]), 64'(req_addr), "request address");
            check_value(64'(exp_tag), 64'(req_tag), "request tag");
            exp_tag = exp_tag + 1'b1;
            void'(exp_req_addr.pop_front());
            pend_tag.push_back(req_tag);
            pend_addr.push_back(req_addr);
            if (pend_tag.size() > N_ENTRIES - 1)
                report_failure("more requests outstanding than the scoreboard can hold");
        end
        if ((pend_tag.size() > 0) && ((pend_tag.size() >= mem_depth) || !req_valid))
        begin
            window = (pend_tag.size() < mem_depth) ? pend_tag.size() : mem_depth;
            pick = int'($urandom % window);
            rsp_valid <= 1'b1;
            rsp_tag   <= pend_tag[pick];
            rsp_data  <= word_for_addr(pend_addr[pick]);
            pend_tag.delete(pick);
            pend_addr.delete(pick);
        end
    end

    // Random stall level on the output, redrawn every cycle
    always @(posedge clk)
    begin : stall_driver
        if (stall_pct > 0)
            out_stall <= (($urandom % 100) < stall_pct);
        else
            out_stall <= 1'b0;
    end

    // Every word must match the head of the expected list, done only with the last word
    always @(posedge clk)
    begin : output_check
        if (resetb && out_valid)
        begin
            if (exp_addr.size() == 0)
                report_failure("output word appeared while none was expected");
            check_value(64'(exp_addr[0]), 64'(out_addr), "out_addr");
            check_value(64'(exp_data[0]), 64'(out_data), "out_data");
            check_value(64'(exp_sum[0]), 64'(out_sum), "out_sum");
            check_value(64'(exp_last[0]), 64'(done), "done with word");
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_sum.pop_front());
            void'(exp_last.pop_front());
        end
        else if (resetb)
        begin
            check_value(64'd0, 64'(done), "done without out_valid");
        end
    end

    // Outputs stay quiet through reset and until the first command
    always @(negedge clk)
    begin : reset_monitor
        if (!started)
        begin
            check_value(64'd0, 64'(busy), "busy before first start");
            check_value(64'd0, 64'(req_valid), "req_valid before first start");
            check_value(64'd0, 64'(out_valid), "out_valid before first start");
            check_value(64'd0, 64'(done), "done before first start");
        end
    end

    // Limit scales with the number of words in the table
    initial
    begin : watchdog
        int limit;
        limit = total_words() * 200 + 1000;
        repeat (limit) @(posedge clk);
        $display("*** FAILED ***");
        $fatal(1, "timeout: run did not finish within %0d cycles", limit);
    end

    task automatic run_burst(input int row);
        int cnt;
        logic [ADDR_BITS-1:0] a;
        logic [DATA_BITS-1:0] w;
        logic [DATA_BITS-1:0] sum;
        cnt = ROW_COUNT[row];
        sum = '0;
        @(posedge clk);
        base_addr <= ADDR_BITS'(ROW_BASE[row]);
        count     <= COUNT_BITS'(cnt);
        start     <= 1'b1;
        mem_depth <= ROW_DEPTH[row];
        stall_pct <= ROW_STALL[row];
        started = 1'b1;
        // Expected requests and words, addresses wrap at the address width
        for (int k = 0; k < cnt; k++)
        begin
            a = ADDR_BITS'(ROW_BASE[row] + k);
            w = word_for_addr(a);
            sum = sum + w;
            exp_req_addr.push_back(a);
            exp_addr.push_back(a);
            exp_data.push_back(w);
            exp_sum.push_back(sum);
            exp_last.push_back(k == cnt - 1);
        end
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        check_value(64'(cnt != 0), 64'(busy), "busy one cycle after start");
        // A second command while busy must be ignored
        if (cnt >= 2)
        begin
            base_addr <= ADDR_BITS'(ROW_BASE[row] ^ 'h8000);
            count     <= COUNT_BITS'(5);
            start     <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        if (cnt == 0)
        begin
            repeat (20)
            begin
                check_value(64'd0, 64'(busy), "busy after zero count");
                check_value(64'd0, 64'(out_valid), "output after zero count");
                @(posedge clk);
            end
        end
        else
        begin
            while (busy)
                @(posedge clk);
            @(negedge clk);
            check_value(64'd0, 64'(exp_req_addr.size()), "requests missing when busy fell");
            do
                @(posedge clk);
            while (!(out_valid && done));
            @(negedge clk);
            check_value(64'd0, 64'(exp_addr.size()), "words missing after done");
        end
    endtask

    initial
    begin : stimulus
        void'($urandom(SEED));
        resetb    = 1'b0;
        start     = 1'b0;
        base_addr = '0;
        count     = '0;
        repeat (4) @(posedge clk);
        resetb <= 1'b1;
        repeat (5) @(posedge clk);
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            run_burst(r);
        end
        @(negedge clk);
        check_value(64'd0, 64'(pend_tag.size()), "responses left in memory model");
        $display("*** PASSED ***");
        $finish;
    end

endmodule
